//--- src/dac_config.svh
`ifndef DAC_CONFIG_SVH
`define DAC_CONFIG_SVH

// Width of one duty value, also the PWM counter width
`define DAC_DUTY_WIDTH 12

// Flops in each two-flop style synchronizer
`define DAC_SYNC_STAGES 2

// Clocks per waveform sample, one full PWM period
`define DAC_SAMPLE_DIV 4096

`endif

//--- src/dac_pkg.sv
`default_nettype none

`include "dac_config.svh"

package dac_pkg;

    // Duty value, number of high clocks per PWM period
    typedef logic [`DAC_DUTY_WIDTH-1:0] duty_t;

    // Source of the duty value played by the PWM
    typedef enum logic {
        SRC_RV = 1'b0,  // Register value over req/ack
        SRC_WG = 1'b1   // Waveform samples from the FIFO
    } src_t;

endpackage

`default_nettype wire

//--- src/synchronizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module synchronizer (
    input  logic clk,
    input  logic arst_n,
    input  logic async_signal,
    output logic sync_signal
);

    logic [`DAC_SYNC_STAGES-1:0] sync_q;  // Flop chain, index 0 samples the input

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= async_signal;  // First stage may go metastable
            for (int i = 1; i < `DAC_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign sync_signal = sync_q[`DAC_SYNC_STAGES-1];  // Last stage is safe to use

endmodule

`default_nettype wire

//--- src/handshake_rx.sv
`timescale 1ns/1ps
`default_nettype none

module handshake_rx (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           req,
    input  dac_pkg::duty_t din,
    output dac_pkg::duty_t dout,
    output logic           load,
    output logic           ack
);

    logic req_sync;  // Req in the local clock domain

    synchronizer req_sync_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .async_signal (req),
        .sync_signal  (req_sync)
    );

    // Ack doubles as the handshake state
    //   req_sync high, ack low  -> new transfer, capture din
    //   req_sync low,  ack high -> sender has dropped req, release ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack  <= 1'b0;
            load <= 1'b0;
        end else begin
            load <= 1'b0;
            if (req_sync && !ack) begin
                ack  <= 1'b1;
                load <= 1'b1;  // One strobe per transfer
            end else if (!req_sync && ack) begin
                ack <= 1'b0;
            end
        end
    end

    // Payload register, din is stable while req is high and ack is low
    always_ff @(posedge clk) begin
        if (req_sync && !ack) begin
            dout <= din;
        end
    end

    // Each load opens a new transfer, so ack was low before it
    assert property (@(posedge clk) disable iff (!arst_n)
        load |-> (ack && !$past(ack)))
        else $error("handshake_rx: load while ack already high");

endmodule

`default_nettype wire

//--- src/async_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module async_rx (
    input  logic           clk,
    input  logic           arst_n,
    input  dac_pkg::duty_t data,
    input  logic           empty,
    output logic           r_en,
    output dac_pkg::duty_t duty_cycle,
    output logic           load
);

    localparam int CNT_W = $clog2(`DAC_SAMPLE_DIV);
    localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(`DAC_SAMPLE_DIV - 1);

    logic [CNT_W-1:0] div_cnt;  // Clocks left in the current sample period
    logic             expired;  // Sample period over, a pop is due

    assign expired = (div_cnt == '0);

    // Pop only when due and data is there, otherwise wait at zero
    assign r_en = expired && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;  // First word is taken as soon as it shows up
            load    <= 1'b0;
        end else begin
            load <= r_en;  // Word is announced the cycle after the pop
            if (r_en) begin
                div_cnt <= CNT_RELOAD;
            end else if (!expired) begin
                div_cnt <= div_cnt - 1'b1;
            end
        end
    end

    // FWFT data is valid during the pop cycle
    always_ff @(posedge clk) begin
        if (r_en) begin
            duty_cycle <= data;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        r_en |-> !empty)
        else $error("async_rx: read from empty FIFO");

    assert property (@(posedge clk) disable iff (!arst_n)
        r_en |=> !r_en)
        else $error("async_rx: read enable held for two cycles");

endmodule

`default_nettype wire

//--- src/dac_source_sel.sv
`timescale 1ns/1ps
`default_nettype none

module dac_source_sel (
    input  logic           clk,
    input  logic           arst_n,
    input  dac_pkg::src_t  select,
    input  dac_pkg::duty_t rv,
    input  dac_pkg::duty_t wg,
    input  logic           rv_load,
    input  logic           wg_load,
    output dac_pkg::duty_t duty,
    output logic           restart
);

    dac_pkg::duty_t rv_q;         // Latest register value
    dac_pkg::duty_t wg_q;         // Latest waveform sample
    dac_pkg::src_t  select_q;     // Select seen in the previous cycle
    logic           sel_changed;
    logic           sel_load;     // Load from the source now selected
    logic           restart_cause;
    dac_pkg::duty_t duty_next;

    assign sel_changed   = (select != select_q);
    assign sel_load      = (select == dac_pkg::SRC_RV) ? rv_load : wg_load;
    assign restart_cause = sel_changed || sel_load;

    // A load in this cycle bypasses the stored copy
    always_comb begin
        if (select == dac_pkg::SRC_RV) begin
            duty_next = rv_load ? rv : rv_q;
        end else begin
            duty_next = wg_load ? wg : wg_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rv_q     <= '0;
            wg_q     <= '0;
            duty     <= '0;
            select_q <= dac_pkg::SRC_RV;  // Matches the synchronizer reset value
            restart  <= 1'b0;
        end else begin
            if (rv_load) rv_q <= rv;
            if (wg_load) wg_q <= wg;
            select_q <= select;
            duty     <= duty_next;
            restart  <= restart_cause;
        end
    end

    // Back-to-back restarts need a fresh cause for each pulse
    assert property (@(posedge clk) disable iff (!arst_n)
        (restart && $past(restart)) |-> ($past(restart_cause) && $past(restart_cause, 2)))
        else $error("dac_source_sel: restart without a cause");

endmodule

`default_nettype wire

//--- src/pwm.sv
`timescale 1ns/1ps
`default_nettype none

module pwm (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           restart,
    input  dac_pkg::duty_t duty_cycle,
    output logic           pwm
);

    dac_pkg::duty_t cnt_q;      // Position in the period, wraps every 4096 clocks
    dac_pkg::duty_t duty_q;     // Duty of the period being played
    dac_pkg::duty_t cnt_next;
    dac_pkg::duty_t duty_next;

    always_comb begin
        if (restart) begin
            cnt_next  = '0;
            duty_next = duty_cycle;
        end else begin
            cnt_next  = cnt_q + 1'b1;
            duty_next = duty_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q  <= '0;
            duty_q <= '0;
            pwm    <= 1'b0;
        end else begin
            cnt_q  <= cnt_next;
            duty_q <= duty_next;
            pwm    <= (cnt_next < duty_next);  // High for duty clocks from position 0
        end
    end

endmodule

`default_nettype wire

//--- src/dac.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module dac (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       dac_source,
    input  logic [`DAC_DUTY_WIDTH-1:0] rv_duty_cycle,
    input  logic                       req,
    output logic                       ack,
    input  logic [`DAC_DUTY_WIDTH-1:0] async_duty_cycle,
    input  logic                       async_empty,
    output logic                       async_r_en,
    output logic                       pwm
);

    dac_pkg::duty_t rv_duty;      // From handshake_rx
    logic           rv_load;
    dac_pkg::duty_t wg_duty;      // From async_rx
    logic           wg_load;
    logic           source_sync;  // Synchronized dac_source
    dac_pkg::src_t  select;
    dac_pkg::duty_t duty;         // From dac_source_sel to the PWM
    logic           restart;

    handshake_rx handshake_rx (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),            // From register domain
        .din    (rv_duty_cycle),
        .dout   (rv_duty),        // To dac_source_sel
        .load   (rv_load),
        .ack    (ack)             // To register domain
    );

    async_rx async_rx (
        .clk        (clk),
        .arst_n     (arst_n),
        .data       (async_duty_cycle),  // From FIFO
        .empty      (async_empty),
        .r_en       (async_r_en),        // To FIFO
        .duty_cycle (wg_duty),           // To dac_source_sel
        .load       (wg_load)
    );

    synchronizer dac_source_sync (
        .clk          (clk),
        .arst_n       (arst_n),
        .async_signal (dac_source),
        .sync_signal  (source_sync)
    );

    assign select = dac_pkg::src_t'(source_sync);  // 0 register, 1 waveform

    dac_source_sel dac_source_sel (
        .clk     (clk),
        .arst_n  (arst_n),
        .select  (select),
        .rv      (rv_duty),
        .wg      (wg_duty),
        .rv_load (rv_load),
        .wg_load (wg_load),
        .duty    (duty),
        .restart (restart)
    );

    pwm aud_pwm (
        .clk        (clk),
        .arst_n     (arst_n),
        .restart    (restart),
        .duty_cycle (duty),
        .pwm        (pwm)       // To analog filter
    );

endmodule

`default_nettype wire

//--- tb/dac_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module dac_tb;

    localparam int PERIOD = `DAC_SAMPLE_DIV;
    localparam int DUTY_MASK = (1 << `DAC_DUTY_WIDTH) - 1;

    logic                       clk;
    logic                       arst_n;
    logic                       dac_source;
    logic [`DAC_DUTY_WIDTH-1:0] rv_duty_cycle;
    logic                       req;
    logic                       ack;
    logic [`DAC_DUTY_WIDTH-1:0] async_duty_cycle;
    logic                       async_empty;
    logic                       async_r_en;
    logic                       pwm;

    int   seed = 11529;
    int   cyc = 0;          // Cycle number, read at the falling edge
    int   n_checks = 0;
    int   n_fail = 0;
    int   n_timeout = 0;
    int   fifo_q[$];        // Words waiting in the FIFO model
    int   win_start_q[$];   // Expected period starts
    int   win_duty_q[$];    // Duty played in each of those periods
    logic pop_due = 1'b0;
    logic wg_check = 1'b0;  // Schedule a period check for each pop
    int   last_pop = -1;
    int   last_start = 0;
    int   last_sample = 0;
    logic win_active = 1'b0;
    int   win_left;
    int   win_high;
    int   win_exp;

    dac u_dac (
        .clk              (clk),
        .arst_n           (arst_n),
        .dac_source       (dac_source),
        .rv_duty_cycle    (rv_duty_cycle),
        .req              (req),
        .ack              (ack),
        .async_duty_cycle (async_duty_cycle),
        .async_empty      (async_empty),
        .async_r_en       (async_r_en),
        .pwm              (pwm)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc = cyc + 1;

    // High clocks in one PWM period for a given duty
    function automatic int expected_high(int duty);
        return (duty < PERIOD) ? duty : PERIOD;
    endfunction

    function int rand_duty();
        return $random(seed) & DUTY_MASK;
    endfunction

    // FWFT FIFO model, pop decided at the previous falling edge
    always @(posedge clk) begin
        if (pop_due && fifo_q.size() > 0) begin
            fifo_q.delete(0);
        end
        async_empty <= (fifo_q.size() == 0);
        async_duty_cycle <= (fifo_q.size() > 0) ? `DAC_DUTY_WIDTH'(fifo_q[0]) : '0;
    end

    // Pop monitor
    always @(negedge clk) begin
        pop_due = async_r_en;
        if (async_r_en) begin
            if (async_empty) begin
                n_fail++;
                $display("FAIL %0t: read enable while FIFO empty", $time);
            end
            if (last_pop >= 0 && cyc - last_pop < PERIOD) begin
                n_fail++;
                $display("FAIL %0t: pops %0d cycles apart", $time, cyc - last_pop);
            end
            last_pop = cyc;
            if (wg_check && fifo_q.size() > 0) begin
                last_start = cyc + 3;  // Period starts 3 cycles after the pop
                last_sample = fifo_q[0];
                win_start_q.push_back(cyc + 3);
                win_duty_q.push_back(fifo_q[0]);
            end
        end
    end

    // Period checker, counts pwm high over one full period
    always @(negedge clk) begin
        if (!win_active && win_start_q.size() > 0 && cyc > win_start_q[0]) begin
            n_fail++;
            $display("Period check starting at cycle %0d was missed", win_start_q[0]);
            win_start_q.delete(0);
            win_duty_q.delete(0);
        end
        if (!win_active && win_start_q.size() > 0 && cyc == win_start_q[0]) begin
            win_active = 1'b1;
            win_left = PERIOD;
            win_high = 0;
            win_exp = expected_high(win_duty_q[0]);
            win_start_q.delete(0);
            win_duty_q.delete(0);
        end
        if (win_active) begin
            if (pwm) win_high++;
            win_left--;
            if (win_left == 0) begin
                win_active = 1'b0;
                n_checks++;
                if (win_high != win_exp) begin
                    n_fail++;
                    $display("FAIL %0t: period high count %0d, expected %0d",
                             $time, win_high, win_exp);
                end
            end
        end
    end

    task automatic wait_checks(int target, int limit, string what);
        int t;
        t = 0;
        while (n_checks < target && t < limit) begin
            @(negedge clk);
            t++;
        end
        if (n_checks < target) begin
            n_timeout++;
            $display("Timed out waiting for the %s period check", what);
        end
    endtask

    // Four-phase transfer, returns the cycle in which ack was first high
    task automatic send_register(int value, output int ack_cyc);
        int t;
        ack_cyc = -1;
        @(posedge clk);
        if (ack) begin
            n_fail++;
            $display("FAIL %0t: ack high before req", $time);
        end
        rv_duty_cycle <= `DAC_DUTY_WIDTH'(value);
        req <= 1'b1;
        t = 0;
        @(negedge clk);
        while (!ack && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (!ack) begin
            n_timeout++;
            $display("Ack did not rise after req was raised");
        end else begin
            ack_cyc = cyc;
        end
        @(posedge clk);
        req <= 1'b0;
        t = 0;
        @(negedge clk);
        while (ack && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (ack) begin
            n_timeout++;
            $display("Ack did not fall after req was dropped");
        end
    endtask

    // Select change reaches the PWM 5 cycles later, check the period after that
    task automatic switch_source(logic src, int duty);
        int c;
        @(negedge clk);
        c = cyc;
        win_start_q.push_back(c + 5 + PERIOD);
        win_duty_q.push_back(duty);
        @(posedge clk);
        dac_source <= src;
    endtask

    initial begin
        int duties[4];
        int ack_cyc;
        int target;
        int start;
        int rv_value;
        arst_n = 1'b0;
        dac_source = 1'b0;
        req = 1'b0;
        rv_duty_cycle = '0;
        async_empty = 1'b1;
        async_duty_cycle = '0;
        target = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        repeat (200) begin  // Idle outputs after reset
            @(negedge clk);
            if (pwm || ack || async_r_en) begin
                n_fail++;
                $display("FAIL %0t: output active after reset", $time);
            end
        end

        duties[0] = 0;
        duties[1] = DUTY_MASK;
        duties[2] = rand_duty();
        duties[3] = rand_duty();
        foreach (duties[i]) begin  // Register source
            send_register(duties[i], ack_cyc);
            if (ack_cyc >= 0) begin
                win_start_q.push_back(ack_cyc + 2 + PERIOD);
                win_duty_q.push_back(duties[i]);
            end
            target++;
            wait_checks(target, 3 * PERIOD, "register");
        end

        @(posedge clk);
        dac_source <= 1'b1;
        repeat (10) @(negedge clk);
        wg_check = 1'b1;
        repeat (3) fifo_q.push_back(rand_duty());
        target += 3;
        wait_checks(target, 4 * PERIOD + 100, "waveform");

        repeat (6000) begin  // FIFO drained, no pops allowed
            @(negedge clk);
            if (async_r_en) begin
                n_fail++;
                $display("FAIL %0t: pop while FIFO empty", $time);
            end
        end
        fifo_q.push_back(rand_duty());
        target++;
        wait_checks(target, 2 * PERIOD, "late waveform");
        wg_check = 1'b0;

        rv_value = rand_duty();  // Stored only, waveform keeps playing
        send_register(rv_value, ack_cyc);
        start = last_start + ((cyc - last_start) / PERIOD + 1) * PERIOD;
        if (start - cyc < 2) start += PERIOD;
        win_start_q.push_back(start);
        win_duty_q.push_back(last_sample);
        target++;
        wait_checks(target, 3 * PERIOD, "unselected load");

        switch_source(1'b0, rv_value);
        target++;
        wait_checks(target, 3 * PERIOD, "switch to register");
        switch_source(1'b1, last_sample);
        target++;
        wait_checks(target, 3 * PERIOD, "switch to waveform");

        $display("checks %0d, wrong values %0d, timeouts %0d", n_checks, n_fail, n_timeout);
        if (n_fail == 0 && n_timeout == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
src/dac_pkg.sv
src/synchronizer.sv
src/handshake_rx.sv
src/async_rx.sv
src/dac_source_sel.sv
src/pwm.sv
src/dac.sv
tb/dac_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the DAC testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module dac_tb \
    -o dac_sim > build.log 2>&1 \
    && ./obj_dir/dac_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "No errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
